// ==== flist.f ====
+incdir+common
common/trg_types_pkg.sv
common/readout_pkg.sv
logic/time_counter.sv
trigger/sample_compare.sv
trigger/trigger_window.sv
readout/event_readout.sv
logic/mm_trigger_top.sv
dv/mm_trigger_properties.sv
dv/mm_trigger_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= mm_trigger_tb
RTL_TOP    ?= mm_trigger_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --assert -Wno-fatal
LINT_FLAGS ?= -Wall
SIM_ARGS   ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/mm_trigger_tb.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module mm_trigger_tb import trg_types_pkg::*, readout_pkg::*;
();

    localparam int TSW = `TRG_TIME_STAMP_WIDTH;
    localparam int SLOTS = `TRG_TDATA_WIDTH / 16;
    localparam int THRESH = ((1 << `TRG_ADC_WIDTH) - 1) * `TRG_THRESHOLD_PCT / 100;
    // enough quiet beats to close any open window
    localparam int QUIET_TAIL = `TRG_POST_ACQUI_LEN + 8;
    localparam int TIMEOUT = 500;
    localparam int ROWS = 8;
    localparam int CLK_PERIOD = 4;

    logic                             AXIS_ACLK = 1'b0;
    logic                             AXIS_ARESETN;
    exec_state_e                      exec_state;
    logic signed [`TRG_ADC_WIDTH-1:0] baseline;
    logic [`TRG_TDATA_WIDTH-1:0]      s_axis_tdata;
    logic                             rdo_ack;
    logic [TSW-1:0]                   current_time;
    logic                             triggered;
    logic                             rdo_req;
    logic [TSW-1:0]                   rdo_time_stamp;
    event_len_t                       rdo_length;
    logic                             rdo_truncated;
    logic                             event_lost;

    // baseline, hit level over baseline, hit slot (SLOTS means every slot),
    // first burst, gap, second burst, bursts, events per burst,
    // first length, second length, truncated, ack delay, ack held
    int table_rows [ROWS][13] = '{
        '{   0, 600, 8,   5,  0, 0, 1, 1,  43,  0, 0, 0, 0},
        '{-200, 409, 5,   1,  0, 0, 1, 1,  39,  0, 0, 2, 0},
        '{ 300, 409, 0,   3,  0, 0, 1, 1,  41,  0, 0, 1, 0},
        '{ 100, 408, 8,  10,  0, 0, 1, 0,   0,  0, 0, 0, 0},
        '{   0, 700, 7, 130,  0, 0, 1, 1, 100,  0, 1, 3, 0},
        '{  50, 500, 2,   4, 37, 6, 1, 1,  85,  0, 0, 0, 0},
        '{  50, 500, 3,   4, 38, 6, 1, 2,  42, 44, 0, 5, 0},
        '{ -50, 450, 8,   2,  0, 0, 5, 1,  40,  0, 0, 1, 1}
    };

    logic [TSW-1:0] exp_time [$];
    int             exp_len [$];
    logic           exp_trunc [$];
    logic           exp_lost = 1'b0;
    time            run_start = 0;

    always #(CLK_PERIOD / 2) AXIS_ACLK = ~AXIS_ACLK;

    mm_trigger_top mm_trigger_top_i (.*);

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_time(input logic [TSW-1:0] got, input logic [TSW-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
                               $time, what, got, exp));
    endtask

    task automatic check_length(input event_len_t got, input event_len_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: rdo_length is %0d, expected %0d",
                               $time, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // one count per clock since the run began
    function automatic logic [TSW-1:0] expected_time();
        return TSW'(($time - run_start) / CLK_PERIOD);
    endfunction

    // records past the FIFO depth are dropped by the DUT
    function automatic void expect_event(input logic [TSW-1:0] ts, input int len,
                                         input int trunc);
        if (exp_time.size() < `TRG_EVENT_FIFO_DEPTH)
        begin
            exp_time.push_back(ts);
            exp_len.push_back(len);
            exp_trunc.push_back(trunc != 0);
        end
        else
        begin
            exp_lost = 1'b1;
        end
    endfunction

    task automatic drive_beat(input int bl, input int level, input int slot, input logic hit);
        int value;
        @(negedge AXIS_ACLK);
        baseline = 12'(bl);
        for (int i = 0; i < SLOTS; i++)
        begin
            // quiet samples stay one count under the threshold at most
            value = bl - (THRESH - 1) + int'($urandom % (2 * THRESH - 1));
            if (hit && (slot == SLOTS || slot == i))
                value = bl + level;
            s_axis_tdata[16*i +: 16] = {value[11:0], 4'($urandom)};
        end
    endtask

    task automatic wait_req(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (rdo_req !== level && cycles < TIMEOUT)
        begin
            @(negedge AXIS_ACLK);
            cycles++;
        end
        if (rdo_req !== level)
            stop_run($sformatf("Timed out waiting for %s", what));
    endtask

    // host side of the four-phase handshake
    task automatic read_event(input int delay);
        wait_req(1'b1, "rdo_req to rise");
        check_time(rdo_time_stamp, exp_time.pop_front(), "rdo_time_stamp");
        check_length(rdo_length, event_len_t'(exp_len.pop_front()));
        check_flag(rdo_truncated, exp_trunc.pop_front(), "rdo_truncated");
        repeat (delay) @(negedge AXIS_ACLK);
        rdo_ack = 1'b1;
        wait_req(1'b0, "rdo_req to fall after the ack");
        rdo_ack = 1'b0;
    endtask

    initial
    begin
        int   row [13];
        int   beats;
        int   cycles;
        logic hit;
        void'($urandom(32'h11c5_dd0d));
        AXIS_ARESETN = 1'b0;
        exec_state = EXEC_INIT;
        baseline = '0;
        s_axis_tdata = '0;
        rdo_ack = 1'b0;
        repeat (2) @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;
        exec_state = EXEC_RUN;
        run_start = $time;

        for (int r = 0; r < ROWS; r++)
        begin
            row = table_rows[r];
            rdo_ack = (row[12] != 0);
            beats = row[3] + row[4] + row[5];
            for (int rep = 0; rep < row[6]; rep++)
            begin
                for (int b = 0; b < beats + QUIET_TAIL; b++)
                begin
                    hit = (b < row[3]) || (b >= row[3] + row[4] && b < beats);
                    drive_beat(row[0], row[1], row[2], hit);
                    check_time(current_time, expected_time(), "current_time");
                    // stamp is the time on the bus with the opening hit
                    if (b == 0 && row[7] > 0)
                        expect_event(expected_time(), row[8], row[10]);
                    if (b == row[3] + row[4] && row[7] == 2)
                        expect_event(expected_time(), row[9], 0);
                    if (b == 2 && rep == 0)
                        check_flag(triggered, row[7] > 0, "triggered");
                end
            end
            rdo_ack = 1'b0;
            while (exp_time.size() > 0)
                read_event(row[11]);
            repeat (4) @(negedge AXIS_ACLK);
            check_flag(rdo_req, 1'b0, "rdo_req after the last record");
            check_flag(event_lost, exp_lost, "event_lost");
        end

        // in init time stays cleared and hits are ignored
        exec_state = EXEC_INIT;
        cycles = 0;
        while (current_time != '0 && cycles < TIMEOUT)
        begin
            @(negedge AXIS_ACLK);
            cycles++;
        end
        if (current_time != '0)
            stop_run("Timed out waiting for current_time to clear in INIT");
        for (int b = 0; b < 20; b++)
        begin
            drive_beat(0, 600, SLOTS, 1'b1);
            check_time(current_time, '0, "current_time in INIT");
            check_flag(triggered, 1'b0, "triggered in INIT");
        end
        repeat (4) @(negedge AXIS_ACLK);
        check_flag(rdo_req, 1'b0, "rdo_req after hits in INIT");
        $display("Test passed");
        $finish;
    end

endmodule

// ==== dv/mm_trigger_properties.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module mm_trigger_properties import trg_types_pkg::*, readout_pkg::*;
(
    input logic                             AXIS_ACLK,
    input logic                             AXIS_ARESETN,
    input exec_state_e                      exec_state,
    input logic                             triggered,
    input logic                             rdo_ack,
    input logic                             rdo_req,
    input logic [`TRG_TIME_STAMP_WIDTH-1:0] rdo_time_stamp,
    input event_len_t                       rdo_length,
    input logic                             rdo_truncated
);

    // a new request only after the host let go of ack
    req_rise_ack_low: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        $rose(rdo_req) |-> !$past(rdo_ack))
    else
        $error("rdo_req rose while rdo_ack was high");

    // head record held through the request phase
    record_stable: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        rdo_req && $past(rdo_req) |-> $stable({rdo_time_stamp, rdo_length, rdo_truncated}))
    else
        $error("record outputs changed while rdo_req was high");

    // zone and trigger state trail exec_state by two edges
    no_trigger_in_init: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        $past(exec_state != EXEC_RUN, 2) |-> !triggered)
    else
        $error("triggered high outside the run state");

endmodule

bind mm_trigger_top mm_trigger_properties mm_trigger_properties_i (
    .AXIS_ACLK      (AXIS_ACLK),
    .AXIS_ARESETN   (AXIS_ARESETN),
    .exec_state     (exec_state),
    .triggered      (triggered),
    .rdo_ack        (rdo_ack),
    .rdo_req        (rdo_req),
    .rdo_time_stamp (rdo_time_stamp),
    .rdo_length     (rdo_length),
    .rdo_truncated  (rdo_truncated)
);

// ==== logic/mm_trigger_top.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module mm_trigger_top import trg_types_pkg::*, readout_pkg::*;
(
    input  logic                             AXIS_ACLK,
    input  logic                             AXIS_ARESETN,
    input  exec_state_e                      exec_state,
    input  logic signed [`TRG_ADC_WIDTH-1:0] baseline,
    input  logic [`TRG_TDATA_WIDTH-1:0]      s_axis_tdata,
    input  logic                             rdo_ack,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0] current_time,
    output logic                             triggered,
    output logic                             rdo_req,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0] rdo_time_stamp,
    output event_len_t                       rdo_length,
    output logic                             rdo_truncated,
    output logic                             event_lost
);

    zone_e                            zone;
    logic [`TRG_TIME_STAMP_WIDTH-1:0] zone_time;
    logic                             event_valid;
    logic [`TRG_TIME_STAMP_WIDTH-1:0] event_time_stamp;
    event_len_t                       event_length;
    logic                             event_truncated;

    time_counter time_counter_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .current_time (current_time)
    );

    sample_compare sample_compare_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .baseline     (baseline),
        .s_axis_tdata (s_axis_tdata),
        .current_time (current_time),
        .zone         (zone),
        .zone_time    (zone_time)
    );

    trigger_window trigger_window_i (
        .AXIS_ACLK        (AXIS_ACLK),
        .AXIS_ARESETN     (AXIS_ARESETN),
        .zone             (zone),
        .zone_time        (zone_time),
        .triggered        (triggered),
        .event_valid      (event_valid),
        .event_time_stamp (event_time_stamp),
        .event_length     (event_length),
        .event_truncated  (event_truncated)
    );

    event_readout event_readout_i (
        .AXIS_ACLK        (AXIS_ACLK),
        .AXIS_ARESETN     (AXIS_ARESETN),
        .event_valid      (event_valid),
        .event_time_stamp (event_time_stamp),
        .event_length     (event_length),
        .event_truncated  (event_truncated),
        .rdo_ack          (rdo_ack),
        .rdo_req          (rdo_req),
        .rdo_time_stamp   (rdo_time_stamp),
        .rdo_length       (rdo_length),
        .rdo_truncated    (rdo_truncated),
        .event_lost       (event_lost)
    );

endmodule

// ==== readout/event_readout.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module event_readout import readout_pkg::*;
(
    input  logic                             AXIS_ACLK,
    input  logic                             AXIS_ARESETN,
    input  logic                             event_valid,
    input  logic [`TRG_TIME_STAMP_WIDTH-1:0] event_time_stamp,
    input  event_len_t                       event_length,
    input  logic                             event_truncated,
    input  logic                             rdo_ack,
    output logic                             rdo_req,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0] rdo_time_stamp,
    output event_len_t                       rdo_length,
    output logic                             rdo_truncated,
    output logic                             event_lost
);

    localparam int DEPTH = `TRG_EVENT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`TRG_TIME_STAMP_WIDTH-1:0] mem_time [DEPTH];
    event_len_t                       mem_len [DEPTH];
    logic                             mem_trunc [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    rdo_state_e       rdo_state;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    // a full FIFO drops the new record
    assign push = event_valid && !full;
    // pop on the ack that ends the request phase
    assign pop = (rdo_state == RDO_REQ) && rdo_ack;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (push)
        begin
            mem_time[wr_ptr] <= event_time_stamp;
            mem_len[wr_ptr] <= event_length;
            mem_trunc[wr_ptr] <= event_truncated;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            event_lost <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            // sticky until reset
            if (event_valid && full)
                event_lost <= 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            rdo_state <= RDO_IDLE;
        end
        else
        begin
            case (rdo_state)
                RDO_IDLE:
                begin
                    if (!empty && !rdo_ack)
                        rdo_state <= RDO_REQ;
                end
                RDO_REQ:
                begin
                    if (rdo_ack)
                        rdo_state <= RDO_ACK_RELEASE;
                end
                RDO_ACK_RELEASE:
                begin
                    // wait for the host to let go of ack
                    if (!rdo_ack)
                        rdo_state <= RDO_IDLE;
                end
                default:
                begin
                    rdo_state <= RDO_IDLE;
                end
            endcase
        end
    end

    assign rdo_req = (rdo_state == RDO_REQ);

    // head record, unchanged until the pop
    assign rdo_time_stamp = mem_time[rd_ptr];
    assign rdo_length = mem_len[rd_ptr];
    assign rdo_truncated = mem_trunc[rd_ptr];

endmodule

// ==== trigger/trigger_window.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module trigger_window import trg_types_pkg::*, readout_pkg::*;
(
    input  logic                             AXIS_ACLK,
    input  logic                             AXIS_ARESETN,
    input  zone_e                            zone,
    input  logic [`TRG_TIME_STAMP_WIDTH-1:0] zone_time,
    output logic                             triggered,
    output logic                             event_valid,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0] event_time_stamp,
    output event_len_t                       event_length,
    output logic                             event_truncated
);

    localparam int POST_W = $clog2(`TRG_POST_ACQUI_LEN + 1);

    trigger_state_e    state;
    event_len_t        win_len;
    event_len_t        len_next;
    logic [POST_W-1:0] quiet_cnt;
    logic [POST_W-1:0] quiet_next;
    logic              is_hit;
    logic              win_start;
    logic              win_open;
    logic              close_quiet;
    logic              close_full;

    always_comb
    begin
        is_hit = (zone == ZONE_HIGH);
        len_next = win_len + 1'b1;
        // quiet run restarts on every hit
        quiet_next = is_hit ? '0 : quiet_cnt + 1'b1;
        // after a truncated window the level must fall before a new start
        win_start = is_hit && ((state == TRG_WAIT) || (state == TRG_END && !event_truncated));
        win_open = (state == TRG_ACTIVE) && (zone != ZONE_CALIB);
        close_quiet = win_open && (quiet_next == `TRG_POST_ACQUI_LEN);
        close_full = win_open && !close_quiet && (len_next == `TRG_ACQUI_LEN);
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state <= TRG_WAIT;
            event_valid <= 1'b0;
            win_len <= '0;
            quiet_cnt <= '0;
        end
        else
        begin
            event_valid <= close_quiet || close_full;

            case (state)
                TRG_WAIT:
                begin
                    if (win_start)
                        state <= TRG_ACTIVE;
                end
                TRG_ACTIVE:
                begin
                    if (zone == ZONE_CALIB)
                        state <= TRG_WAIT;
                    else if (close_quiet || close_full)
                        state <= TRG_END;
                end
                TRG_END:
                begin
                    if (win_start)
                        state <= TRG_ACTIVE;
                    else if (!is_hit)
                        state <= TRG_WAIT;
                end
                default:
                begin
                    state <= TRG_WAIT;
                end
            endcase

            // first hit counts as beat one
            if (win_start)
            begin
                win_len <= event_len_t'(1);
                quiet_cnt <= '0;
            end
            else if (win_open)
            begin
                win_len <= len_next;
                quiet_cnt <= quiet_next;
            end
        end
    end

    // record fields, the FIFO takes them while event_valid is high
    always_ff @(posedge AXIS_ACLK)
    begin
        if (win_start)
            event_time_stamp <= zone_time;
        if (close_quiet || close_full)
        begin
            event_length <= len_next;
            event_truncated <= close_full;
        end
    end

    assign triggered = (state == TRG_ACTIVE);

endmodule

// ==== trigger/sample_compare.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module sample_compare import trg_types_pkg::*;
(
    input  logic                                AXIS_ACLK,
    input  logic                                AXIS_ARESETN,
    input  exec_state_e                         exec_state,
    input  logic signed [`TRG_ADC_WIDTH-1:0]    baseline,
    input  logic [`TRG_TDATA_WIDTH-1:0]         s_axis_tdata,
    input  logic [`TRG_TIME_STAMP_WIDTH-1:0]    current_time,
    output zone_e                               zone,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0]    zone_time
);

    localparam int ADC_W = `TRG_ADC_WIDTH;
    localparam int SLOT_W = 16;
    localparam int SLOTS = `TRG_TDATA_WIDTH / SLOT_W;
    localparam int FULL_RANGE = 2**ADC_W - 1;
    localparam int THRESHOLD_INT = FULL_RANGE * `TRG_THRESHOLD_PCT / 100;
    // one extra bit so sample minus baseline cannot wrap
    localparam logic signed [ADC_W:0] THRESHOLD_VAL = THRESHOLD_INT[ADC_W:0];

    logic signed [ADC_W-1:0] sample [SLOTS];
    logic signed [ADC_W:0]   diff [SLOTS];
    logic                    hit;

    // sample sits in the upper bits of each 16-bit slot
    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < SLOTS; i++)
        begin
            sample[i] = s_axis_tdata[SLOT_W*i + SLOT_W-1 -: ADC_W];
            diff[i] = {sample[i][ADC_W-1], sample[i]} - {baseline[ADC_W-1], baseline};
            hit = hit | (diff[i] >= THRESHOLD_VAL);
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            zone <= ZONE_CALIB;
        end
        else if (exec_state != EXEC_RUN)
        begin
            zone <= ZONE_CALIB;
        end
        else
        begin
            zone <= hit ? ZONE_HIGH : ZONE_LOW;
        end
    end

    // time of the beat travels with its zone
    always_ff @(posedge AXIS_ACLK)
    begin
        zone_time <= current_time;
    end

endmodule

// ==== logic/time_counter.sv ====
`timescale 1ns/100ps

`include "trg_macros.svh"

module time_counter import trg_types_pkg::*;
(
    input  logic                             AXIS_ACLK,
    input  logic                             AXIS_ARESETN,
    input  exec_state_e                      exec_state,
    output logic [`TRG_TIME_STAMP_WIDTH-1:0] current_time
);

    // runs only while armed, held at zero otherwise
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            current_time <= '0;
        end
        else if (exec_state == EXEC_RUN)
        begin
            current_time <= current_time + 1'b1;
        end
        else
        begin
            current_time <= '0;
        end
    end

endmodule

// ==== common/readout_pkg.sv ====
`include "trg_macros.svh"

package readout_pkg;

    // four-phase req/ack states
    typedef enum logic [1:0]
    {
        RDO_IDLE        = 2'b00,
        RDO_REQ         = 2'b01,
        RDO_ACK_RELEASE = 2'b10
    } rdo_state_e;

    // holds any length up to the full window
    typedef logic [$clog2(`TRG_ACQUI_LEN + 1)-1:0] event_len_t;

endpackage

// ==== common/trg_types_pkg.sv ====
package trg_types_pkg;

    // run control from the host, unused codes behave as init
    typedef enum logic [1:0]
    {
        EXEC_INIT = 2'b00,
        EXEC_RUN  = 2'b11
    } exec_state_e;

    // where the current beat sits relative to the threshold
    typedef enum logic [1:0]
    {
        ZONE_LOW   = 2'b00,
        ZONE_CALIB = 2'b01,
        ZONE_HIGH  = 2'b11
    } zone_e;

    // acquisition window state
    typedef enum logic [1:0]
    {
        TRG_WAIT   = 2'b00,
        TRG_ACTIVE = 2'b01,
        TRG_END    = 2'b11
    } trigger_state_e;

endpackage

// ==== common/trg_macros.svh ====
`ifndef TRG_MACROS_SVH
`define TRG_MACROS_SVH

// threshold in percent of the full 12-bit range, 409 counts
`define TRG_THRESHOLD_PCT 10

// non-hit beats that close a window
`define TRG_POST_ACQUI_LEN 38

// longest window in beats
`define TRG_ACQUI_LEN 100

`define TRG_TIME_STAMP_WIDTH 16
`define TRG_ADC_WIDTH 12
`define TRG_TDATA_WIDTH 128

// event records held before readout
`define TRG_EVENT_FIFO_DEPTH 4

`endif
